// File: hw/spm_input_sampler.sv
`include "spm_params.svh"

module spm_input_sampler (
    input  logic             a_clk,
    input  logic             rst_n,
    input  spm_pkg::sample_t xs,
    input  spm_pkg::sample_t ys,
    input  spm_pkg::sample_t zs,
    input  spm_pkg::sample_t us,
    input  spm_pkg::sample_t rotm_xx,
    input  spm_pkg::sample_t rotm_xy,
    input  spm_pkg::sample_t slope_x,
    input  spm_pkg::sample_t slope_y,
    input  spm_pkg::sample_t x0,
    input  spm_pkg::sample_t y0,
    input  spm_pkg::sample_t z0,
    input  spm_pkg::sample_t u0,
    input  spm_pkg::sample_t xy_step,
    input  spm_pkg::sample_t z_step,
    output logic             update,
    output spm_pkg::sample_t xs_s,
    output spm_pkg::sample_t ys_s,
    output spm_pkg::sample_t zs_s,
    output spm_pkg::sample_t us_s,
    output spm_pkg::sample_t rotm_xx_s,
    output spm_pkg::sample_t rotm_xy_s,
    output spm_pkg::sample_t slope_x_s,
    output spm_pkg::sample_t slope_y_s,
    output spm_pkg::sample_t x0_s,
    output spm_pkg::sample_t y0_s,
    output spm_pkg::sample_t z0_s,
    output spm_pkg::sample_t u0_s,
    output spm_pkg::sample_t xy_step_s,
    output spm_pkg::sample_t z_step_s
);

    logic [`SPM_RDECI-1:0] dec_cnt;

    ////////////////////////////////////////////////////////////
    // Rate divider, strobe on counter wrap
    ////////////////////////////////////////////////////////////
    always_ff @(posedge a_clk)
    begin
        if (!rst_n)
        begin
            dec_cnt <= '0;
            update  <= 1'b0;
        end
        else
        begin
            dec_cnt <= dec_cnt + 1'b1;
            update  <= (dec_cnt == '1);
        end
    end

    ////////////////////////////////////////////////////////////
    // Control inputs held between strobes
    ////////////////////////////////////////////////////////////
    always_ff @(posedge a_clk)
    begin
        if (!rst_n)
        begin
            xs_s      <= '0;
            ys_s      <= '0;
            zs_s      <= '0;
            us_s      <= '0;
            rotm_xx_s <= '0;
            rotm_xy_s <= '0;
            slope_x_s <= '0;
            slope_y_s <= '0;
            x0_s      <= '0;
            y0_s      <= '0;
            z0_s      <= '0;
            u0_s      <= '0;
            xy_step_s <= '0;
            z_step_s  <= '0;
        end
        else if (update)
        begin
            xs_s      <= xs;
            ys_s      <= ys;
            zs_s      <= zs;
            us_s      <= us;
            rotm_xx_s <= rotm_xx;
            rotm_xy_s <= rotm_xy;
            slope_x_s <= slope_x;
            slope_y_s <= slope_y;
            x0_s      <= x0;
            y0_s      <= y0;
            z0_s      <= z0;
            u0_s      <= u0;
            xy_step_s <= xy_step;
            z_step_s  <= z_step;
        end
    end

endmodule

// File: hw/spm_offset_slew.sv
module spm_offset_slew (
    input  logic             a_clk,
    input  logic             rst_n,
    input  logic             update,
    input  spm_pkg::sample_t target,
    input  spm_pkg::sample_t step,
    output spm_pkg::sample_t position
);

    spm_pkg::sample_t pos_up;
    spm_pkg::sample_t pos_dn;

    // Reachable window around the current position
    // Caller keeps position +/- step inside the signed range
    assign pos_up = position + step;
    assign pos_dn = position - step;

    always_ff @(posedge a_clk)
    begin
        if (!rst_n)
        begin
            position <= '0;
        end
        else if (update)
        begin
            if (target > pos_up)
            begin
                position <= pos_up;
            end
            else if (target < pos_dn)
            begin
                position <= pos_dn;
            end
            else
            begin
                // Within one step, land exactly on target
                position <= target;
            end
        end
    end

endmodule

// File: hw/spm_params.svh
`ifndef SPM_PARAMS_SVH
`define SPM_PARAMS_SVH

// Data word width of every stream
`define SPM_W 32

// Fraction bits of rotation and slope coefficients (Q28)
`define SPM_QROTM 28

// Decimation bits, update every 2^SPM_RDECI clocks
`define SPM_RDECI 2

`endif

// File: hw/spm_pkg.sv
`include "spm_params.svh"

package spm_pkg;

    // One data word on any port
    typedef logic signed [`SPM_W-1:0] sample_t;

    // Sum of two coefficient x sample products
    typedef logic signed [`SPM_W+`SPM_QROTM+2-1:0] product_t;

    // Z sum ahead of saturation, headroom for four terms
    typedef logic signed [`SPM_W+4-1:0] zsum_t;

    // Symmetric saturation limits, +/-(2^31-1)
    localparam zsum_t SAT_MAX = zsum_t'({1'b0, {(`SPM_W-1){1'b1}}});
    localparam zsum_t SAT_MIN = -SAT_MAX;

endpackage

// File: hw/spm_scan_control.sv
module spm_scan_control (
    input  logic             a_clk,
    input  logic             rst_n,
    input  spm_pkg::sample_t xs,
    input  spm_pkg::sample_t ys,
    input  spm_pkg::sample_t zs,
    input  spm_pkg::sample_t us,
    input  spm_pkg::sample_t rotm_xx,
    input  spm_pkg::sample_t rotm_xy,
    input  spm_pkg::sample_t slope_x,
    input  spm_pkg::sample_t slope_y,
    input  spm_pkg::sample_t x0,
    input  spm_pkg::sample_t y0,
    input  spm_pkg::sample_t z0,
    input  spm_pkg::sample_t u0,
    input  spm_pkg::sample_t xy_step,
    input  spm_pkg::sample_t z_step,
    input  spm_pkg::sample_t z_servo,
    output spm_pkg::sample_t x_drive,
    output spm_pkg::sample_t y_drive,
    output spm_pkg::sample_t z_drive,
    output spm_pkg::sample_t u_drive,
    output spm_pkg::sample_t x0_mon,
    output spm_pkg::sample_t y0_mon,
    output spm_pkg::sample_t z0_mon,
    output spm_pkg::sample_t xs_mon,
    output spm_pkg::sample_t ys_mon,
    output spm_pkg::sample_t zs_mon,
    output spm_pkg::sample_t u0_mon,
    output logic             out_update
);

    logic             update;
    spm_pkg::sample_t xs_s, ys_s, zs_s, us_s;
    spm_pkg::sample_t rotm_xx_s, rotm_xy_s, slope_x_s, slope_y_s;
    spm_pkg::sample_t x0_s, y0_s, z0_s, u0_s;
    spm_pkg::sample_t xy_step_s, z_step_s;
    spm_pkg::sample_t xr, yr;

    ////////////////////////////////////////////////////////////
    // Sampling at the reduced rate
    ////////////////////////////////////////////////////////////
    spm_input_sampler sampler_i (
        .a_clk(a_clk), .rst_n(rst_n),
        .xs(xs), .ys(ys), .zs(zs), .us(us),
        .rotm_xx(rotm_xx), .rotm_xy(rotm_xy),
        .slope_x(slope_x), .slope_y(slope_y),
        .x0(x0), .y0(y0), .z0(z0), .u0(u0),
        .xy_step(xy_step), .z_step(z_step),
        .update(update),
        .xs_s(xs_s), .ys_s(ys_s), .zs_s(zs_s), .us_s(us_s),
        .rotm_xx_s(rotm_xx_s), .rotm_xy_s(rotm_xy_s),
        .slope_x_s(slope_x_s), .slope_y_s(slope_y_s),
        .x0_s(x0_s), .y0_s(y0_s), .z0_s(z0_s), .u0_s(u0_s),
        .xy_step_s(xy_step_s), .z_step_s(z_step_s)
    );

    // Offset followers, X and Y share one step
    spm_offset_slew x0_slew_i (
        .a_clk(a_clk), .rst_n(rst_n), .update(update),
        .target(x0_s), .step(xy_step_s), .position(x0_mon)
    );

    spm_offset_slew y0_slew_i (
        .a_clk(a_clk), .rst_n(rst_n), .update(update),
        .target(y0_s), .step(xy_step_s), .position(y0_mon)
    );

    spm_offset_slew z0_slew_i (
        .a_clk(a_clk), .rst_n(rst_n), .update(update),
        .target(z0_s), .step(z_step_s), .position(z0_mon)
    );

    ////////////////////////////////////////////////////////////
    // Rotation, then Z and bias
    ////////////////////////////////////////////////////////////
    spm_scan_rotator rotator_i (
        .a_clk(a_clk), .rst_n(rst_n), .update(update),
        .xs(xs_s), .ys(ys_s), .rotm_xx(rotm_xx_s), .rotm_xy(rotm_xy_s),
        .x0_pos(x0_mon), .y0_pos(y0_mon),
        .xr(xr), .yr(yr), .x_drive(x_drive), .y_drive(y_drive)
    );

    spm_z_bias_stage z_bias_i (
        .a_clk(a_clk), .rst_n(rst_n), .update(update),
        .xr(xr), .yr(yr), .slope_x(slope_x_s), .slope_y(slope_y_s),
        .z0_pos(z0_mon), .zs(zs_s), .z_servo(z_servo),
        .u0(u0_s), .us(us_s),
        .z_drive(z_drive), .u_drive(u_drive), .z_servo_mon(zs_mon)
    );

    assign xs_mon = xs_s;
    assign ys_mon = ys_s;
    assign u0_mon = u0_s;

    // Marks the clock where drives carry a fresh update
    always_ff @(posedge a_clk)
    begin
        if (!rst_n)
        begin
            out_update <= 1'b0;
        end
        else
        begin
            out_update <= update;
        end
    end

endmodule

// File: hw/spm_scan_rotator.sv
`include "spm_params.svh"

module spm_scan_rotator (
    input  logic             a_clk,
    input  logic             rst_n,
    input  logic             update,
    input  spm_pkg::sample_t xs,
    input  spm_pkg::sample_t ys,
    input  spm_pkg::sample_t rotm_xx,
    input  spm_pkg::sample_t rotm_xy,
    input  spm_pkg::sample_t x0_pos,
    input  spm_pkg::sample_t y0_pos,
    output spm_pkg::sample_t xr,
    output spm_pkg::sample_t yr,
    output spm_pkg::sample_t x_drive,
    output spm_pkg::sample_t y_drive
);

    spm_pkg::product_t rot_x;
    spm_pkg::product_t rot_y;

    ////////////////////////////////////////////////////////////
    // Stage 1, rotation products in Q28
    ////////////////////////////////////////////////////////////
    // yx = -xy and yy = xx, so one cos/sin pair suffices
    always_ff @(posedge a_clk)
    begin
        if (!rst_n)
        begin
            rot_x <= '0;
            rot_y <= '0;
        end
        else if (update)
        begin
            rot_x <= spm_pkg::product_t'(rotm_xx) * spm_pkg::product_t'(xs)
                   + spm_pkg::product_t'(rotm_xy) * spm_pkg::product_t'(ys);
            rot_y <= spm_pkg::product_t'(rotm_xx) * spm_pkg::product_t'(ys)
                   - spm_pkg::product_t'(rotm_xy) * spm_pkg::product_t'(xs);
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 2, back to word scale plus absolute offsets
    ////////////////////////////////////////////////////////////
    always_ff @(posedge a_clk)
    begin
        if (!rst_n)
        begin
            xr      <= '0;
            yr      <= '0;
            x_drive <= '0;
            y_drive <= '0;
        end
        else if (update)
        begin
            xr      <= spm_pkg::sample_t'(rot_x >>> `SPM_QROTM);
            yr      <= spm_pkg::sample_t'(rot_y >>> `SPM_QROTM);
            x_drive <= spm_pkg::sample_t'(rot_x >>> `SPM_QROTM) + x0_pos;
            y_drive <= spm_pkg::sample_t'(rot_y >>> `SPM_QROTM) + y0_pos;
        end
    end

endmodule

// File: hw/spm_z_bias_stage.sv
`include "spm_params.svh"

module spm_z_bias_stage (
    input  logic             a_clk,
    input  logic             rst_n,
    input  logic             update,
    input  spm_pkg::sample_t xr,
    input  spm_pkg::sample_t yr,
    input  spm_pkg::sample_t slope_x,
    input  spm_pkg::sample_t slope_y,
    input  spm_pkg::sample_t z0_pos,
    input  spm_pkg::sample_t zs,
    input  spm_pkg::sample_t z_servo,
    input  spm_pkg::sample_t u0,
    input  spm_pkg::sample_t us,
    output spm_pkg::sample_t z_drive,
    output spm_pkg::sample_t u_drive,
    output spm_pkg::sample_t z_servo_mon
);

    spm_pkg::product_t slope_prod;
    spm_pkg::sample_t  servo_r;
    spm_pkg::sample_t  slope_term;
    spm_pkg::zsum_t    z_sum;

    assign slope_term  = spm_pkg::sample_t'(slope_prod >>> `SPM_QROTM);
    assign z_servo_mon = servo_r;

    ////////////////////////////////////////////////////////////
    // Z pipeline, slope products, sum, saturate
    ////////////////////////////////////////////////////////////
    always_ff @(posedge a_clk)
    begin
        if (!rst_n)
        begin
            slope_prod <= '0;
            servo_r    <= '0;
            u_drive    <= '0;
            z_sum      <= '0;
            z_drive    <= '0;
        end
        else if (update)
        begin
            // Plane correction from the rotated scan vector
            slope_prod <= spm_pkg::product_t'(slope_x) * spm_pkg::product_t'(xr)
                        + spm_pkg::product_t'(slope_y) * spm_pkg::product_t'(yr);
            servo_r    <= z_servo;
            u_drive    <= u0 + us;

            z_sum <= spm_pkg::zsum_t'(z0_pos) + spm_pkg::zsum_t'(zs)
                   + spm_pkg::zsum_t'(servo_r) + spm_pkg::zsum_t'(slope_term);

            // Clip symmetric, never to -2^31
            if (z_sum > spm_pkg::SAT_MAX)
            begin
                z_drive <= spm_pkg::sample_t'(spm_pkg::SAT_MAX);
            end
            else if (z_sum < spm_pkg::SAT_MIN)
            begin
                z_drive <= spm_pkg::sample_t'(spm_pkg::SAT_MIN);
            end
            else
            begin
                z_drive <= spm_pkg::sample_t'(z_sum);
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_spm_scan_control -o tb_sim

out=$(./obj_dir/tb_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Test passed'
then
    exit 0
fi
exit 1

// File: src.f
+incdir+hw
hw/spm_pkg.sv
hw/spm_input_sampler.sv
hw/spm_offset_slew.sv
hw/spm_scan_rotator.sv
hw/spm_z_bias_stage.sv
hw/spm_scan_control.sv
verification/tb_clock.sv
verification/tb_spm_scan_control.sv

// File: verification/tb_clock.sv
module tb_clock (
    output logic a_clk,
    output logic rst_n
);

    // Free-running clock, period 20
    initial
    begin
        a_clk = 1'b0;
        forever
        begin
            #10 a_clk = ~a_clk;
        end
    end

    // Low over two rising edges, released on a falling edge
    initial
    begin
        rst_n = 1'b0;
        repeat (2) @(posedge a_clk);
        @(negedge a_clk);
        rst_n = 1'b1;
    end

endmodule

// File: verification/tb_spm_scan_control.sv
`include "spm_params.svh"

module tb_spm_scan_control;

    logic             a_clk;
    logic             rst_n;
    spm_pkg::sample_t xs, ys, zs, us, rotm_xx, rotm_xy, slope_x, slope_y;
    spm_pkg::sample_t x0, y0, z0, u0, xy_step, z_step, z_servo;
    spm_pkg::sample_t x_drive, y_drive, z_drive, u_drive;
    spm_pkg::sample_t x0_mon, y0_mon, z0_mon, xs_mon, ys_mon, zs_mon, u0_mon;
    logic             out_update;

    logic [31:0] rng = 32'h4139_10c6;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_err = 0;
    int          gap;
    int          n;
    logic        hung = 1'b0;
    longint      px, py, pz, xr_m, yr_m;

    tb_clock clock_i (.a_clk(a_clk), .rst_n(rst_n));

    spm_scan_control dut_i (.*);

    ////////////////////////////////////////////////////////////
    // Stimulus and model helpers
    ////////////////////////////////////////////////////////////
    // Xorshift32 scaled into +/- 2^(bits-1)
    function automatic spm_pkg::sample_t rand_signed(input int bits);
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return $signed(rng) >>> (32 - bits);
    endfunction

    // X component xx*xs + xy*ys in word scale
    function automatic longint rot_x_model();
        return (longint'(rotm_xx) * longint'(xs) + longint'(rotm_xy) * longint'(ys))
            >>> `SPM_QROTM;
    endfunction

    // Y component xx*ys - xy*xs
    function automatic longint rot_y_model();
        return (longint'(rotm_xx) * longint'(ys) - longint'(rotm_xy) * longint'(xs))
            >>> `SPM_QROTM;
    endfunction

    function automatic longint slew_next(input longint pos, input longint tgt,
                                         input longint step);
        if (tgt > pos + step)
        begin
            return pos + step;
        end
        else if (tgt < pos - step)
        begin
            return pos - step;
        end
        return tgt;
    endfunction

    // Symmetric clip to +/-(2^31-1)
    function automatic longint saturate(input longint v);
        if (v > 64'sh7fff_ffff)
        begin
            return 64'sh7fff_ffff;
        end
        else if (v < -64'sh7fff_ffff)
        begin
            return -64'sh7fff_ffff;
        end
        return v;
    endfunction

    task automatic check_value(input string name, input spm_pkg::sample_t got,
                               input spm_pkg::sample_t want);
        if (!hung)
        begin
            checks++;
            assert (got === want)
            else
            begin
                $display("Error: %s is %h, expected %h", name, got, want);
                errors++;
            end
        end
    endtask

    // Waits for the next out_update pulse 2 units after the edge
    task automatic wait_out_update(output int clocks);
        logic seen;
        seen = 1'b0;
        clocks = 0;
        while (!seen && !hung)
        begin
            @(posedge a_clk);
            #2;
            clocks++;
            seen = out_update;
            if (!seen && clocks >= 16)
            begin
                $display("Timeout: no out_update pulse within 16 clocks");
                errors++;
                hung = 1'b1;
            end
        end
    endtask

    task automatic wait_updates(input int count);
        int clocks;
        repeat (count) wait_out_update(clocks);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_err)
        begin
            $display("%s: ok", name);
        end
        else
        begin
            $display("%s: %0d errors", name, errors - test_err);
        end
        test_err = errors;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        xs = '0;
        ys = '0;
        zs = '0;
        us = '0;
        rotm_xx = '0;
        rotm_xy = '0;
        slope_x = '0;
        slope_y = '0;
        x0 = '0;
        y0 = '0;
        z0 = '0;
        u0 = '0;
        xy_step = '0;
        z_step = '0;
        z_servo = '0;
        gap = 0;
        while (rst_n !== 1'b1 && !hung)
        begin
            @(posedge a_clk);
            #2;
            gap++;
            if (gap > 10)
            begin
                $display("Timeout: reset was never released");
                errors++;
                hung = 1'b1;
            end
        end

        check_value("x_drive", x_drive, 0);
        check_value("y_drive", y_drive, 0);
        check_value("z_drive", z_drive, 0);
        check_value("u_drive", u_drive, 0);
        check_value("x0_mon", x0_mon, 0);
        check_value("y0_mon", y0_mon, 0);
        check_value("z0_mon", z0_mon, 0);
        check_value("xs_mon", xs_mon, 0);
        check_value("ys_mon", ys_mon, 0);
        check_value("zs_mon", zs_mon, 0);
        check_value("u0_mon", u0_mon, 0);
        wait_out_update(gap);
        repeat (4)
        begin
            wait_out_update(gap);
            check_value("out_update period", spm_pkg::sample_t'(gap), 4);
        end
        end_test("reset and strobe");

        xs = rand_signed(25);
        ys = rand_signed(25);
        rotm_xx = rand_signed(29);
        rotm_xy = rand_signed(29);
        x0 = x0_mon;
        y0 = y0_mon;
        wait_updates(6);
        check_value("x_drive", x_drive, spm_pkg::sample_t'(rot_x_model() + longint'(x0_mon)));
        check_value("y_drive", y_drive, spm_pkg::sample_t'(rot_y_model() + longint'(y0_mon)));
        end_test("rotation");

        px = longint'(x0_mon);
        py = longint'(y0_mon);
        pz = longint'(z0_mon);
        xy_step = 32'h0040_0000 + (rand_signed(32) & 32'h003f_ffff);
        z_step = 32'h0040_0000 + (rand_signed(32) & 32'h003f_ffff);
        x0 = x0_mon + rand_signed(27);
        y0 = y0_mon + rand_signed(27);
        z0 = z0_mon + rand_signed(27);
        // Targets are sampled on this strobe and positions move from the next
        wait_out_update(gap);
        check_value("x0_mon", x0_mon, spm_pkg::sample_t'(px));
        n = 0;
        while ((px != longint'(x0) || py != longint'(y0) || pz != longint'(z0)) && n < 40)
        begin
            wait_out_update(gap);
            px = slew_next(px, longint'(x0), longint'(xy_step));
            py = slew_next(py, longint'(y0), longint'(xy_step));
            pz = slew_next(pz, longint'(z0), longint'(z_step));
            check_value("x0_mon", x0_mon, spm_pkg::sample_t'(px));
            check_value("y0_mon", y0_mon, spm_pkg::sample_t'(py));
            check_value("z0_mon", z0_mon, spm_pkg::sample_t'(pz));
            n++;
        end
        end_test("offset slew");

        zs = rand_signed(25);
        us = rand_signed(30);
        u0 = rand_signed(30);
        z_servo = rand_signed(25);
        slope_x = rand_signed(25);
        slope_y = rand_signed(25);
        wait_updates(8);
        xr_m = rot_x_model();
        yr_m = rot_y_model();
        // Drives now include the slewed offsets
        check_value("x_drive", x_drive, spm_pkg::sample_t'(xr_m + longint'(x0)));
        check_value("y_drive", y_drive, spm_pkg::sample_t'(yr_m + longint'(y0)));
        check_value("z_drive", z_drive, spm_pkg::sample_t'(saturate(longint'(z0_mon)
            + longint'(zs) + longint'(z_servo)
            + ((longint'(slope_x) * xr_m + longint'(slope_y) * yr_m) >>> `SPM_QROTM))));
        check_value("u_drive", u_drive, u0 + us);
        check_value("zs_mon", zs_mon, z_servo);
        end_test("z and bias");

        zs = 32'h4000_0000;
        z_servo = 32'h7fff_ffff;
        wait_updates(6);
        check_value("z_drive", z_drive, 32'h7fff_ffff);
        zs = 32'hc000_0000;
        z_servo = 32'h8000_0000;
        wait_updates(6);
        check_value("z_drive", z_drive, 32'h8000_0001);
        end_test("saturation");

        xs = rand_signed(25);
        ys = rand_signed(25);
        u0 = rand_signed(30);
        wait_updates(2);
        check_value("xs_mon", xs_mon, xs);
        check_value("ys_mon", ys_mon, ys);
        check_value("u0_mon", u0_mon, u0);
        end_test("monitors");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && !hung)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
